// File: design/pizza_pkg.sv
// Shared pixel, coordinate and direction types plus game constants, referenced by every module
package pizza_pkg;

	// One pixel position on the 160x120 plane
	typedef struct packed {
		logic [7:0] x;   // Column
		logic [6:0] y;   // Row
	} coord_t;

	typedef logic [2:0] colour_t;   // RGB, one bit per channel

	// Courier heading as read from the direction input
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'b00,
		DIR_DOWN  = 2'b01,
		DIR_LEFT  = 2'b10,
		DIR_UP    = 2'b11
	} dir_t;

	// One write towards the frame buffer
	typedef struct packed {
		logic    plot;     // Write strobe
		coord_t  pos;
		colour_t colour;
	} pixel_t;

	localparam colour_t COLOUR_YELLOW = 3'b111;   // Paint
	localparam colour_t COLOUR_BLACK  = 3'b000;   // Erase

	localparam int BOX_SIDE        = 4;    // Every box is square
	localparam int BOX_PIXELS      = 16;   // BOX_SIDE squared
	localparam int HOUSE_COUNT     = 15;   // Houses per scatter
	localparam int FRAMES_PER_STEP = 16;   // Frames the courier rests between moves

	localparam coord_t COURIER_START = '{x: 8'd0, y: 7'd21};

	// Possible house corners, indexed by the LFSR value
	localparam coord_t HOUSE_TABLE [16] = '{
		'{x: 8'd4,   y: 7'd4},
		'{x: 8'd4,   y: 7'd36},
		'{x: 8'd4,   y: 7'd68},
		'{x: 8'd4,   y: 7'd100},
		'{x: 8'd36,  y: 7'd4},
		'{x: 8'd52,  y: 7'd36},
		'{x: 8'd52,  y: 7'd68},
		'{x: 8'd52,  y: 7'd100},
		'{x: 8'd68,  y: 7'd4},
		'{x: 8'd100, y: 7'd36},
		'{x: 8'd100, y: 7'd68},
		'{x: 8'd100, y: 7'd100},
		'{x: 8'd100, y: 7'd4},
		'{x: 8'd148, y: 7'd36},
		'{x: 8'd148, y: 7'd68},
		'{x: 8'd148, y: 7'd100}
	};

	// LFSR state after reset, must be non-zero
	localparam logic [3:0] LFSR_SEED = 4'b0001;

endpackage

// File: design/box_painter.sv
// Paints one 4x4 box as 16 back to back pixel writes for the house scatter and the courier
`timescale 1ns/1ns

module box_painter (
	input  logic               clk,
	input  logic               resetn,
	input  logic               start,    // Taken only while idle
	input  pizza_pkg::coord_t  origin,   // Top left corner
	input  pizza_pkg::colour_t colour,
	output pizza_pkg::pixel_t  pix,
	output logic               done      // Pulse after the last write
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DRAW,
		S_FINISH
	} state_t;

	state_t                                   state;
	pizza_pkg::coord_t                        origin_q;   // Latched on start
	pizza_pkg::colour_t                       colour_q;
	logic [$clog2(pizza_pkg::BOX_PIXELS)-1:0] cnt;        // Pixel index inside the box
	logic [$clog2(pizza_pkg::BOX_SIDE)-1:0]   x_off;
	logic [$clog2(pizza_pkg::BOX_SIDE)-1:0]   y_off;

	// Raster order with the low counter bits walking along the row
	assign {y_off, x_off} = cnt;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (start)
						state <= S_DRAW;
				end
				S_DRAW: begin
					cnt <= cnt + 1'b1;
					if (int'(cnt) == pizza_pkg::BOX_PIXELS - 1)
						state <= S_FINISH;   // Last pixel goes out this cycle
				end
				S_FINISH: state <= S_IDLE;
				default:  state <= S_IDLE;
			endcase
		end
	end

	// Box corner and colour held for the whole burst
	always_ff @(posedge clk) begin
		if (state == S_IDLE && start) begin
			origin_q <= origin;
			colour_q <= colour;
		end
	end

	always_comb begin
		pix.plot   = (state == S_DRAW);
		pix.pos.x  = origin_q.x + 8'(x_off);
		pix.pos.y  = origin_q.y + 7'(y_off);
		pix.colour = colour_q;
	end

	assign done = (state == S_FINISH);

	// A burst is 16 writes in a row followed by a single done cycle
	a_burst: assert property (@(posedge clk) disable iff (!resetn)
		$rose(pix.plot) |-> pix.plot [*pizza_pkg::BOX_PIXELS]
			##1 (done && !pix.plot) ##1 !done);

endmodule

// File: design/house_lfsr.sv
// Free running 4-bit LFSR that picks a house corner from the table every cycle
`timescale 1ns/1ns

module house_lfsr (
	input  logic              clk,
	input  logic              resetn,
	output pizza_pkg::coord_t house   // Corner for the current LFSR value
);

	logic [3:0] lfsr;
	logic       feedback;

	// Taps on bits 3 and 2 give the full 15 state cycle
	assign feedback = lfsr[3] ^ lfsr[2];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			lfsr <= pizza_pkg::LFSR_SEED;
		else
			lfsr <= {lfsr[2:0], feedback};   // Shift towards the MSB
	end

	// Table lookup, entry 0 is never reached since the LFSR skips zero
	assign house = pizza_pkg::HOUSE_TABLE[lfsr];

endmodule

// File: design/house_scatter.sv
// Sequencer that paints the yellow house boxes after go and then holds scatter_done
`timescale 1ns/1ns

module house_scatter (
	input  logic              clk,
	input  logic              resetn,
	input  logic              go,            // Start pulse
	output pizza_pkg::pixel_t pix,
	output logic              scatter_done   // High until reset once all houses are out
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PAINT,
		S_COUNT,
		S_COUNT_WAIT,
		S_LOAD,
		S_LOAD_WAIT,
		S_DONE
	} state_t;

	state_t            state;
	logic [3:0]        box_cnt;   // Houses painted so far
	logic              all_boxes;
	logic              box_done;
	logic              box_start;
	pizza_pkg::coord_t house;     // Live LFSR pick
	pizza_pkg::coord_t house_q;   // Pick held for the painter

	house_lfsr lfsr_i (
		.clk    (clk),
		.resetn (resetn),
		.house  (house)
	);

	assign all_boxes = (int'(box_cnt) == pizza_pkg::HOUSE_COUNT);
	assign box_start = (state == S_LOAD_WAIT) && !all_boxes;   // Painter idle here

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state   <= S_IDLE;
			box_cnt <= '0;
		end else begin
			case (state)
				S_IDLE:       if (go) state <= S_LOAD;
				S_PAINT:      if (box_done) state <= S_COUNT;
				S_COUNT: begin
					box_cnt <= box_cnt + 1'b1;
					state   <= S_COUNT_WAIT;
				end
				S_COUNT_WAIT: state <= S_LOAD;
				S_LOAD:       state <= S_LOAD_WAIT;
				S_LOAD_WAIT:  state <= all_boxes ? S_DONE : S_PAINT;
				default:      state <= S_DONE;   // Done holds until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_LOAD)
			house_q <= house;
	end

	box_painter painter_i (
		.clk    (clk),
		.resetn (resetn),
		.start  (box_start),
		.origin (house_q),
		.colour (pizza_pkg::COLOUR_YELLOW),
		.pix    (pix),
		.done   (box_done)
	);

	assign scatter_done = (state == S_DONE);

	// No house write may still be in flight once the top hands the output to the courier
	a_done_quiet: assert property (@(posedge clk) disable iff (!resetn)
		scatter_done |-> !pix.plot);

endmodule

// File: design/frame_pacer.sv
// Frame timer for the courier, counts clocks into frames and frames into one step pulse
`timescale 1ns/1ns

module frame_pacer #(
	parameter int tick_cycles = 833333   // Clocks per frame, 1/60 s at 50 MHz
) (
	input  logic clk,
	input  logic resetn,
	input  logic enable,   // Low clears both counters
	output logic step      // One cycle pulse per FRAMES_PER_STEP frames
);

	logic [$clog2(tick_cycles+1)-1:0]              tick_cnt;
	logic [$clog2(pizza_pkg::FRAMES_PER_STEP)-1:0] frame_cnt;
	logic                                          tick_last;
	logic                                          frame_last;

	assign tick_last  = (int'(tick_cnt) == tick_cycles - 1);
	assign frame_last = (int'(frame_cnt) == pizza_pkg::FRAMES_PER_STEP - 1);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			tick_cnt  <= '0;
			frame_cnt <= '0;
			step      <= 1'b0;
		end else if (!enable) begin
			tick_cnt  <= '0;
			frame_cnt <= '0;
			step      <= 1'b0;
		end else begin
			step <= tick_last && frame_last;   // End of the last frame
			if (tick_last) begin
				tick_cnt  <= '0;
				frame_cnt <= frame_last ? '0 : frame_cnt + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

// File: design/courier_move.sv
// Courier sequencer that paints the delivery box, waits a step, erases it and moves it
`timescale 1ns/1ns

module courier_move #(
	parameter int tick_cycles = 833333
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              start,       // Level that rises once the houses are done
	input  pizza_pkg::dir_t   direction,   // Heading from the player
	output pizza_pkg::pixel_t pix
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PAINT,
		S_COUNT,
		S_ERASE,
		S_LOAD,
		S_LOAD_WAIT
	} state_t;

	state_t             state;
	pizza_pkg::coord_t  pos_q;       // Current box corner
	pizza_pkg::coord_t  next_pos;
	pizza_pkg::dir_t    dir_q;       // Heading taken at erase done
	logic               step;
	logic               box_done;
	logic               box_start;
	pizza_pkg::colour_t box_colour;

	// Held high through a paint or erase and taken by the painter only when idle
	assign box_start  = (state == S_PAINT || state == S_ERASE) && !box_done;
	assign box_colour = (state == S_ERASE) ? pizza_pkg::COLOUR_BLACK
	                                       : pizza_pkg::COLOUR_YELLOW;

	// One pixel move with natural wrap of each coordinate
	always_comb begin
		next_pos = pos_q;
		case (dir_q)
			pizza_pkg::DIR_RIGHT: next_pos.x = pos_q.x + 8'd1;
			pizza_pkg::DIR_DOWN:  next_pos.y = pos_q.y + 7'd1;
			pizza_pkg::DIR_LEFT:  next_pos.x = pos_q.x - 8'd1;
			default:              next_pos.y = pos_q.y - 7'd1;   // Up
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			pos_q <= pizza_pkg::COURIER_START;
			dir_q <= pizza_pkg::DIR_RIGHT;
		end else begin
			case (state)
				S_IDLE:  if (start) state <= S_PAINT;
				S_PAINT: if (box_done) state <= S_COUNT;
				S_COUNT: if (step) state <= S_ERASE;
				S_ERASE: begin
					if (box_done) begin
						dir_q <= direction;   // Sampled as the erase ends
						state <= S_LOAD;
					end
				end
				S_LOAD: begin
					pos_q <= next_pos;
					state <= S_LOAD_WAIT;
				end
				S_LOAD_WAIT: state <= S_PAINT;
				default:     state <= S_IDLE;
			endcase
		end
	end

	frame_pacer #(
		.tick_cycles (tick_cycles)
	) pacer_i (
		.clk    (clk),
		.resetn (resetn),
		.enable (state == S_COUNT),
		.step   (step)
	);

	box_painter painter_i (
		.clk    (clk),
		.resetn (resetn),
		.start  (box_start),
		.origin (pos_q),
		.colour (box_colour),
		.pix    (pix),
		.done   (box_done)
	);

	// Corner holds through every burst so erase and repaint hit the same pixels
	a_pos_held: assert property (@(posedge clk) disable iff (!resetn)
		pix.plot |-> $stable(pos_q));

endmodule

// File: design/pizza_delivery.sv
// Top level of the pizza game, merges house scatter and courier writes into one pixel stream
`timescale 1ns/1ns

module pizza_delivery #(
	parameter int tick_cycles = 833333   // Clocks per frame
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              go,          // Starts the house scatter
	input  pizza_pkg::dir_t   direction,   // Courier heading
	output pizza_pkg::pixel_t pix          // One write per cycle to the frame buffer
);

	pizza_pkg::pixel_t scatter_pix;
	pizza_pkg::pixel_t courier_pix;
	logic              scatter_done;   // Also the courier start level

	house_scatter scatter_i (
		.clk          (clk),
		.resetn       (resetn),
		.go           (go),
		.pix          (scatter_pix),
		.scatter_done (scatter_done)
	);

	courier_move #(
		.tick_cycles (tick_cycles)
	) courier_i (
		.clk       (clk),
		.resetn    (resetn),
		.start     (scatter_done),
		.direction (direction),
		.pix       (courier_pix)
	);

	// Houses own the output until the scatter ends, the courier after that
	assign pix = scatter_done ? courier_pix : scatter_pix;

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset source, 4 ns clock and active low reset held for the first cycles
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic resetn
);

	localparam int HALF_PERIOD  = 2;   // 4 ns period
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		resetn = 1'b0;                       // In reset from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		resetn <= 1'b1;                      // Released on a rising edge
	end

endmodule

// File: tb/pizza_tb.sv
// Random stimulus testbench for the pizza game, rebuilds every box and checks it against a model
`timescale 1ns/1ns

module pizza_tb;

	localparam int MOVES           = 12;
	localparam int TOTAL_BOXES     = pizza_pkg::HOUSE_COUNT + 1 + 2 * MOVES;
	localparam int TICK_CYCLES     = 2;      // Short frames so a move is tens of cycles
	localparam int QUIET_CYCLES    = pizza_pkg::FRAMES_PER_STEP * TICK_CYCLES;
	localparam int RESET_TIMEOUT   = 100;    // Cycles
	localparam int SCATTER_TIMEOUT = 2000;   // Go to first courier box
	localparam int MOVE_TIMEOUT    = 400;    // One erase plus repaint

	logic              clk;
	logic              resetn;
	logic              go;
	pizza_pkg::dir_t   direction;
	pizza_pkg::pixel_t pix;

	integer             seed;
	logic               go_sent;         // Plot is illegal before this
	int                 box_count;       // Completed boxes of any kind
	int                 courier_boxes;   // Completed yellow courier boxes
	int                 px_idx;          // Writes seen in the open box, 0 between boxes
	pizza_pkg::coord_t  box_origin;
	pizza_pkg::colour_t box_colour;
	pizza_pkg::coord_t  last_yellow;     // Where the courier box should sit now
	pizza_pkg::dir_t    move_dir;        // Heading seen during the last erase

	tb_clock clock_i (
		.clk    (clk),
		.resetn (resetn)
	);

	pizza_delivery #(
		.tick_cycles (TICK_CYCLES)
	) dut_i (
		.clk       (clk),
		.resetn    (resetn),
		.go        (go),
		.direction (direction),
		.pix       (pix)
	);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_coord(input pizza_pkg::coord_t got, input pizza_pkg::coord_t exp,
	                           input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got (%0d,%0d) expected (%0d,%0d)",
			                    $time, what, got.x, got.y, exp.x, exp.y));
	endtask

	task automatic check_colour(input pizza_pkg::colour_t got, input pizza_pkg::colour_t exp,
	                            input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
			                    $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
			                    $time, what, got, exp));
	endtask

	// Position of pixel idx in raster order, four per row
	function automatic pizza_pkg::coord_t raster_pos(input pizza_pkg::coord_t origin,
	                                                 input int idx);
		pizza_pkg::coord_t p;
		p.x = origin.x + 8'(idx % pizza_pkg::BOX_SIDE);
		p.y = origin.y + 7'(idx / pizza_pkg::BOX_SIDE);
		return p;
	endfunction

	function automatic logic in_house_table(input pizza_pkg::coord_t c);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 16; i++)
			if (pizza_pkg::HOUSE_TABLE[i] == c)
				hit = 1'b1;
		return hit;
	endfunction

	// One pixel step with each coordinate wrapping at its register width
	function automatic pizza_pkg::coord_t moved_pos(input pizza_pkg::coord_t p,
	                                                input pizza_pkg::dir_t d);
		pizza_pkg::coord_t n;
		n = p;
		case (d)
			pizza_pkg::DIR_RIGHT: n.x = p.x + 8'd1;
			pizza_pkg::DIR_DOWN:  n.y = p.y + 7'd1;
			pizza_pkg::DIR_LEFT:  n.x = p.x - 8'd1;
			default:              n.y = p.y - 7'd1;
		endcase
		return n;
	endfunction

	// Sorts a finished box into houses, courier start, erase or repaint
	task automatic close_box();
		pizza_pkg::coord_t exp_pos;
		if (box_count < pizza_pkg::HOUSE_COUNT) begin
			check_colour(box_colour, pizza_pkg::COLOUR_YELLOW, "house colour");
			check_flag(in_house_table(box_origin), 1'b1, "house origin found in table");
		end else if (box_count == pizza_pkg::HOUSE_COUNT) begin
			check_colour(box_colour, pizza_pkg::COLOUR_YELLOW, "courier start colour");
			check_coord(box_origin, pizza_pkg::COURIER_START, "courier start origin");
			last_yellow   = pizza_pkg::COURIER_START;
			courier_boxes = courier_boxes + 1;
		end else if ((box_count - pizza_pkg::HOUSE_COUNT) % 2 == 1) begin
			check_colour(box_colour, pizza_pkg::COLOUR_BLACK, "erase colour");
			check_coord(box_origin, last_yellow, "erase origin");
			move_dir = direction;   // Still the heading the DUT samples next edge
		end else begin
			exp_pos = moved_pos(last_yellow, move_dir);
			check_colour(box_colour, pizza_pkg::COLOUR_YELLOW, "courier colour");
			check_coord(box_origin, exp_pos, "courier origin after move");
			last_yellow   = exp_pos;
			courier_boxes = courier_boxes + 1;
		end
		box_count = box_count + 1;
	endtask

	// Output sampled on the falling edge away from the drive edge
	always @(negedge clk) begin
		if (resetn) begin
			if (!go_sent) begin
				check_flag(pix.plot, 1'b0, "plot before go");
			end else if (px_idx > 0) begin
				check_flag(pix.plot, 1'b1, "plot inside a box");
				check_coord(pix.pos, raster_pos(box_origin, px_idx), "box pixel position");
				check_colour(pix.colour, box_colour, "box pixel colour");
				px_idx = px_idx + 1;
				if (px_idx == pizza_pkg::BOX_PIXELS) begin
					close_box();
					px_idx = 0;
				end
			end else if (pix.plot) begin
				box_origin = pix.pos;   // First write sits on the corner
				box_colour = pix.colour;
				px_idx     = 1;
			end
		end
	end

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (!resetn && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!resetn)
			abort_run($sformatf("Timed out at %0t ns waiting for reset to end", $time));
	endtask

	task automatic wait_courier_box(input int target, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (courier_boxes < target && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (courier_boxes < target)
			abort_run($sformatf("Timed out at %0t ns waiting for %s", $time, what));
	endtask

	initial begin
		logic [31:0] rnd;
		int          idle_cycles;
		seed          = 32'h45bf;
		go_sent       = 1'b0;
		box_count     = 0;
		courier_boxes = 0;
		px_idx        = 0;
		move_dir      = pizza_pkg::DIR_RIGHT;
		go           <= 1'b0;
		direction    <= pizza_pkg::DIR_RIGHT;

		wait_reset_release();
		rnd         = $random(seed);
		idle_cycles = 3 + int'(rnd % 20);   // Quiet stretch before go
		repeat (idle_cycles) @(posedge clk);
		go      <= 1'b1;
		go_sent  = 1'b1;
		@(posedge clk);
		go <= 1'b0;

		wait_courier_box(1, SCATTER_TIMEOUT, "the houses and the first courier box");
		for (int m = 0; m < MOVES; m++) begin
			rnd        = $random(seed);
			direction <= pizza_pkg::dir_t'(rnd[1:0]);   // New heading right after a repaint
			wait_courier_box(m + 2, MOVE_TIMEOUT, $sformatf("courier move %0d", m + 1));
		end

		// The courier rests a whole step after its last repaint so no write belongs here
		repeat (QUIET_CYCLES) @(posedge clk);
		check_flag(logic'(box_count == TOTAL_BOXES), 1'b1, "box count at end of run");
		check_flag(logic'(px_idx == 0), 1'b1, "no box left open at end of run");
		$display("All tests passed");
		$finish;
	end

endmodule

// File: filelist.f
design/pizza_pkg.sv
design/box_painter.sv
design/house_lfsr.sv
design/house_scatter.sv
design/frame_pacer.sv
design/courier_move.sv
design/pizza_delivery.sv
tb/tb_clock.sv
tb/pizza_tb.sv

// File: Bender.yml
package:
  name: pizza_delivery

sources:
  - files:
      - design/pizza_pkg.sv
      - design/box_painter.sv
      - design/house_lfsr.sv
      - design/house_scatter.sv
      - design/frame_pacer.sv
      - design/courier_move.sv
      - design/pizza_delivery.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/pizza_tb.sv
